//--- sources.f
src/box_pkg.sv
src/line_buffer.sv
src/window_sum.sv
src/thresh_regs.sv
src/binarize.sv
src/box_thresh_top.sv
verif/box_thresh_checker.sv
verif/box_thresh_tb.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module box_thresh_tb -f sources.f \
    -o box_thresh_sim \
    && ./obj_dir/box_thresh_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

//--- verif/box_thresh_tb.sv
`timescale 1ns/1ps
`default_nettype none

module box_thresh_tb;
    import box_pkg::*;

    localparam int COLS = 8;
    localparam int ROWS = 6;
    localparam int NPIX = COLS * ROWS;
    localparam int NWIN = (COLS - WIN + 1) * (ROWS - WIN + 1);
    localparam int RST_CYCLES = 8;
    localparam int DRAIN = 10;
    localparam int N_TESTS = 7;
    localparam int CYCLE_LIMIT = N_TESTS * (NPIX * 2 + DRAIN) + RST_CYCLES;

    typedef enum logic [1:0] {PAT_CONST, PAT_RAMP, PAT_LFSR} pat_e;

    typedef struct packed {
        pat_e             pattern;
        logic [PIX_W-1:0] level;
        logic [SUM_W-1:0] offset;
        logic             invert;
        logic             gap;
    } test_t;

    typedef struct packed {
        logic [SUM_W-1:0] sum;
        logic [PIX_W-1:0] center;
        logic             bin;
    } exp_t;

    // pattern, level, offset, invert, gap
    test_t tests [N_TESTS] = '{
        '{PAT_CONST, 8'd100, 13'd0,    1'b0, 1'b0},
        '{PAT_RAMP,  8'd0,   13'd0,    1'b0, 1'b0},
        '{PAT_LFSR,  8'd0,   13'd0,    1'b0, 1'b0},
        '{PAT_LFSR,  8'd0,   13'd100,  1'b0, 1'b0},
        '{PAT_LFSR,  8'd0,   13'd100,  1'b1, 1'b0},
        '{PAT_LFSR,  8'd0,   13'd0,    1'b0, 1'b1},
        '{PAT_CONST, 8'd255, 13'd8191, 1'b1, 1'b1}
    };

    logic             clk;
    logic             rst;
    logic             pix_valid;
    logic [PIX_W-1:0] pix;
    logic             cfg_we;
    cfg_addr_e        cfg_addr;
    logic [SUM_W-1:0] cfg_data;
    logic             out_valid;
    logic             out_bin;
    logic [SUM_W-1:0] out_sum;
    logic [PIX_W-1:0] out_center;

    logic [PIX_W-1:0] img [NPIX];
    exp_t             exp_q [$];
    logic [15:0]      lfsr;
    int               cycle_cnt = 0;
    int               pulse_total = 0;
    int               mon_errs = 0;
    int               loop_errs = 0;

    box_thresh_top #(.COLS(COLS), .ROWS(ROWS)) i_box_thresh_top (
        .clk         (clk),
        .rst         (rst),
        .i_pix_valid (pix_valid),
        .i_pix       (pix),
        .i_cfg_we    (cfg_we),
        .i_cfg_addr  (cfg_addr),
        .i_cfg_data  (cfg_data),
        .o_valid     (out_valid),
        .o_bin       (out_bin),
        .o_sum       (out_sum),
        .o_center    (out_center)
    );

    bind box_thresh_top box_thresh_checker i_box_thresh_checker (
        .clk         (clk),
        .rst         (rst),
        .i_pix_valid (i_pix_valid),
        .o_valid     (o_valid),
        .o_sum       (o_sum)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    // compare every output pulse with the oldest expected window
    always @(posedge clk) begin : monitor
        exp_t e;
        int   bad;
        bad = 0;
        if (!rst && out_valid) begin
            pulse_total <= pulse_total + 1;
            if (exp_q.size() == 0) begin
                $display("time %0t: output pulse arrived while no window was expected", $time);
                bad = 1;
            end else begin
                e = exp_q.pop_front();
                if (out_sum !== e.sum) begin
                    $display("Fail at %0t: o_sum got %0d expected %0d", $time, out_sum, e.sum);
                    bad++;
                end
                if (out_center !== e.center) begin
                    $display("Fail at %0t: o_center got %0d expected %0d",
                             $time, out_center, e.center);
                    bad++;
                end
                if (out_bin !== e.bin) begin
                    $display("Fail at %0t: o_bin got %0b expected %0b", $time, out_bin, e.bin);
                    bad++;
                end
            end
        end
        mon_errs <= mon_errs + bad;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic string pat_name(input pat_e p);
        case (p)
            PAT_CONST: return "constant";
            PAT_RAMP:  return "ramp";
            default:   return "lfsr";
        endcase
    endfunction

    task automatic write_cfg(input test_t t);
        @(posedge clk);
        cfg_we   <= 1'b1;
        cfg_addr <= CFG_OFFSET;
        cfg_data <= t.offset;
        @(posedge clk);
        cfg_addr <= CFG_INVERT;
        cfg_data <= SUM_W'(t.invert);
        @(posedge clk);
        cfg_we <= 1'b0;
    endtask

    task automatic build_frame(input test_t t);
        logic [PIX_W-1:0] v;
        for (int i = 0; i < NPIX; i++) begin
            case (t.pattern)
                PAT_CONST: v = t.level;
                PAT_RAMP:  v = PIX_W'(i * 5);
                default: begin
                    // one step per pixel bit
                    for (int b = 0; b < PIX_W; b++) begin
                        lfsr = lfsr_step(lfsr);
                        v[b] = lfsr[0];
                    end
                end
            endcase
            img[i] = v;
        end
    endtask

    // windows in raster order of their bottom-right corner
    task automatic model_frame(input test_t t);
        exp_t e;
        int   s;
        for (int r = WIN - 1; r < ROWS; r++) begin
            for (int c = WIN - 1; c < COLS; c++) begin
                s = 0;
                for (int dr = 0; dr < WIN; dr++) begin
                    for (int dc = 0; dc < WIN; dc++) begin
                        s += int'(img[(r - dr) * COLS + (c - dc)]);
                    end
                end
                e.sum    = SUM_W'(s);
                e.center = img[(r - WIN / 2) * COLS + (c - WIN / 2)];
                e.bin    = (25 * int'(e.center) > s + int'(t.offset)) ^ t.invert;
                exp_q.push_back(e);
            end
        end
    endtask

    task automatic drive_frame(input logic gap);
        for (int i = 0; i < NPIX; i++) begin
            @(posedge clk);
            pix_valid <= 1'b1;
            pix       <= img[i];
            if (gap) begin
                @(posedge clk);
                pix_valid <= 1'b0;
            end
        end
        @(posedge clk);
        pix_valid <= 1'b0;
    endtask

    task automatic run_test(input int n, output int errs);
        int start;
        int idle;
        int got;
        errs  = mon_errs + loop_errs;
        start = pulse_total;
        write_cfg(tests[n]);
        build_frame(tests[n]);
        model_frame(tests[n]);
        drive_frame(tests[n].gap);
        idle = 0;
        while (pulse_total - start < NWIN && idle < DRAIN) begin
            @(posedge clk);
            idle++;
        end
        got = pulse_total - start;
        if (got != NWIN) begin
            $display("test %0d: expected %0d windows but %0d arrived", n, NWIN, got);
            loop_errs++;
            exp_q.delete();
        end
        errs = mon_errs + loop_errs - errs;
        $display("test %0d %s offset %0d invert %0b gap %0b: %0d windows, %0d errors",
                 n, pat_name(tests[n].pattern), tests[n].offset, tests[n].invert,
                 tests[n].gap, got, errs);
    endtask

    initial begin
        int errs;
        int failed;
        int total;
        int asserts;
        failed    = 0;
        rst       = 1'b1;
        pix_valid = 1'b0;
        pix       = '0;
        cfg_we    = 1'b0;
        cfg_addr  = CFG_OFFSET;
        cfg_data  = '0;
        lfsr      = 16'd94;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < N_TESTS; n++) begin
            run_test(n, errs);
            if (errs != 0) begin
                failed++;
            end
        end
        repeat (WIN) @(posedge clk);
        asserts = i_box_thresh_top.i_box_thresh_checker.fails_reset
                + i_box_thresh_top.i_box_thresh_checker.fails_range
                + i_box_thresh_top.i_box_thresh_checker.fails_latency;
        if (asserts != 0) begin
            $display("checker saw %0d assertion failures", asserts);
        end
        total = mon_errs + loop_errs + asserts;
        $display("tests %0d, failed %0d, windows %0d, errors %0d",
                 N_TESTS, failed, pulse_total, total);
        if (total == 0 && failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/box_thresh_checker.sv
`timescale 1ns/1ps
`default_nettype none

module box_thresh_checker (
    input wire logic                      clk,
    input wire logic                      rst,
    input wire logic                      i_pix_valid,
    input wire logic                      o_valid,
    input wire logic [box_pkg::SUM_W-1:0] o_sum
);
    import box_pkg::*;

    localparam int MAX_SUM = WIN * WIN * ((1 << PIX_W) - 1);

    int fails_reset = 0;
    int fails_range = 0;
    int fails_latency = 0;

    // pipeline is four registers deep, so nothing leaves right after reset
    a_quiet_after_reset: assert property (@(posedge clk)
        o_valid |-> !($past(rst, 1) || $past(rst, 2) || $past(rst, 3) || $past(rst, 4)))
    else begin
        $error("o_valid high within four cycles of reset");
        fails_reset++;
    end

    a_sum_range: assert property (@(posedge clk) disable iff (rst)
        o_sum <= SUM_W'(MAX_SUM))
    else begin
        $error("o_sum %0d above the largest possible window sum", o_sum);
        fails_range++;
    end

    // each pulse belongs to the corner pixel accepted four cycles earlier
    a_latency: assert property (@(posedge clk) disable iff (rst)
        o_valid |-> $past(i_pix_valid, 4))
    else begin
        $error("o_valid without an accepted pixel four cycles earlier");
        fails_latency++;
    end

endmodule

`default_nettype wire

//--- src/box_thresh_top.sv
`timescale 1ns/1ps
`default_nettype none

module box_thresh_top #(
    parameter int COLS = 8,
    parameter int ROWS = 6
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      i_pix_valid,
    input  wire logic [box_pkg::PIX_W-1:0] i_pix,
    input  wire logic                      i_cfg_we,
    input  wire box_pkg::cfg_addr_e        i_cfg_addr,
    input  wire logic [box_pkg::SUM_W-1:0] i_cfg_data,
    output logic                           o_valid,
    output logic                           o_bin,
    output logic [box_pkg::SUM_W-1:0]      o_sum,
    output logic [box_pkg::PIX_W-1:0]      o_center
);
    import box_pkg::*;

    col_t col;
    win_t win;
    cfg_t cfg;

    line_buffer #(.COLS(COLS), .ROWS(ROWS)) i_line_buffer (
        .clk         (clk),
        .rst         (rst),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .o_col       (col)
    );

    window_sum #(.COLS(COLS)) i_window_sum (
        .clk   (clk),
        .rst   (rst),
        .i_col (col),
        .o_win (win)
    );

    thresh_regs i_thresh_regs (
        .clk        (clk),
        .rst        (rst),
        .i_cfg_we   (i_cfg_we),
        .i_cfg_addr (i_cfg_addr),
        .i_cfg_data (i_cfg_data),
        .o_cfg      (cfg)
    );

    binarize i_binarize (
        .clk      (clk),
        .rst      (rst),
        .i_win    (win),
        .i_cfg    (cfg),
        .o_valid  (o_valid),
        .o_bin    (o_bin),
        .o_sum    (o_sum),
        .o_center (o_center)
    );

endmodule

`default_nettype wire

//--- src/binarize.sv
`timescale 1ns/1ps
`default_nettype none

module binarize (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire box_pkg::win_t             i_win,
    input  wire box_pkg::cfg_t             i_cfg,
    output logic                           o_valid,
    output logic                           o_bin,
    output logic [box_pkg::SUM_W-1:0]      o_sum,
    output logic [box_pkg::PIX_W-1:0]      o_center
);
    import box_pkg::*;

    // 25 * 255 fits in PIX_W + 5 bits
    localparam int SCL_W = PIX_W + 5;
    localparam int CMP_W = SUM_W + 1;

    logic [SCL_W-1:0] center_x25;
    logic [CMP_W-1:0] limit;
    logic             above;

    // 25c = 16c + 8c + c
    assign center_x25 = (SCL_W'(i_win.center) << 4) + (SCL_W'(i_win.center) << 3)
                        + SCL_W'(i_win.center);

    // one extra bit so sum plus offset cannot wrap
    assign limit = CMP_W'(i_win.sum) + CMP_W'(i_cfg.offset);
    assign above = CMP_W'(center_x25) > limit;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid  <= 1'b0;
            o_bin    <= 1'b0;
            o_sum    <= '0;
            o_center <= '0;
        end else begin
            o_valid <= i_win.valid;
            if (i_win.valid) begin
                o_bin    <= above ^ i_cfg.invert;
                o_sum    <= i_win.sum;
                o_center <= i_win.center;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/thresh_regs.sv
`timescale 1ns/1ps
`default_nettype none

module thresh_regs (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      i_cfg_we,
    input  wire box_pkg::cfg_addr_e        i_cfg_addr,
    input  wire logic [box_pkg::SUM_W-1:0] i_cfg_data,
    output box_pkg::cfg_t                  o_cfg
);
    import box_pkg::*;

    logic [SUM_W-1:0] offset_q;
    logic             invert_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            offset_q <= '0;
            invert_q <= 1'b0;
        end else if (i_cfg_we) begin
            case (i_cfg_addr)
                CFG_OFFSET: begin
                    offset_q <= i_cfg_data;
                end
                CFG_INVERT: begin
                    // only the low data bit is kept
                    invert_q <= i_cfg_data[0];
                end
                default: begin
                end
            endcase
        end
    end

    assign o_cfg = '{offset: offset_q, invert: invert_q};

endmodule

`default_nettype wire

//--- src/window_sum.sv
`timescale 1ns/1ps
`default_nettype none

module window_sum #(
    parameter int COLS = 8
) (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire box_pkg::col_t i_col,
    output box_pkg::win_t      o_win
);
    import box_pkg::*;

    localparam int CW = $clog2(COLS);
    localparam int CTR = WIN / 2;

    // stage 1 registers
    logic                s1_valid;
    logic                s1_first;
    logic [COLSUM_W-1:0] s1_sum;
    logic [PIX_W-1:0]    s1_center;

    logic [COLSUM_W-1:0] col_add;

    // stage 2 state with the newest column in entry 0
    logic [COLSUM_W-1:0] hist_sum [WIN];
    logic [PIX_W-1:0]    hist_ctr [WIN];
    logic [SUM_W-1:0]    run_q;
    logic [CW-1:0]       cnt_q;
    logic                win_valid_q;

    logic [CW-1:0]    new_idx;
    logic [SUM_W-1:0] old_sum;

    // vertical sum of the five pixels
    always_comb begin
        col_add = '0;
        for (int r = 0; r < WIN; r++) begin
            col_add = col_add + COLSUM_W'(i_col.pix[r]);
        end
    end

    // column index of the column entering stage 2
    assign new_idx = s1_first ? '0 : cnt_q + 1'b1;

    // column leaving the window counts only once five are in
    assign old_sum = (int'(new_idx) >= WIN) ? SUM_W'(hist_sum[WIN - 1]) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid    <= 1'b0;
            win_valid_q <= 1'b0;
            cnt_q       <= '0;
        end else begin
            s1_valid    <= i_col.valid;
            win_valid_q <= s1_valid && (int'(new_idx) >= WIN - 1);
            if (s1_valid) begin
                cnt_q <= new_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_col.valid) begin
            s1_sum    <= col_add;
            s1_center <= i_col.pix[CTR];
            s1_first  <= i_col.first;
        end

        if (s1_valid) begin
            hist_sum[0] <= s1_sum;
            hist_ctr[0] <= s1_center;
            for (int k = 1; k < WIN; k++) begin
                hist_sum[k] <= hist_sum[k - 1];
                hist_ctr[k] <= hist_ctr[k - 1];
            end

            // first column of a row restarts the running sum
            if (s1_first) begin
                run_q <= SUM_W'(s1_sum);
            end else begin
                run_q <= run_q + SUM_W'(s1_sum) - old_sum;
            end
        end
    end

    // centre column sits two entries behind the newest one
    assign o_win = '{valid: win_valid_q, sum: run_q, center: hist_ctr[CTR]};

endmodule

`default_nettype wire

//--- src/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffer #(
    parameter int COLS = 8,
    parameter int ROWS = 6
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      i_pix_valid,
    input  wire logic [box_pkg::PIX_W-1:0] i_pix,
    output box_pkg::col_t                  o_col
);
    import box_pkg::*;

    localparam int CW = $clog2(COLS);
    localparam int RW = $clog2(ROWS);
    localparam int NBUF = WIN - 1;

    // rows_q[0] holds the oldest stored row
    logic [PIX_W-1:0] rows_q [NBUF][COLS];

    logic [CW-1:0] col_cnt;
    logic [RW-1:0] row_cnt;

    logic                      valid_q;
    logic                      first_q;
    logic [WIN-1:0][PIX_W-1:0] pix_q;

    // raster position of the incoming pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt <= '0;
            row_cnt <= '0;
            valid_q <= 1'b0;
        end else begin
            // a full column only exists once four rows are stored
            valid_q <= i_pix_valid && (int'(row_cnt) >= NBUF);
            if (i_pix_valid) begin
                if (col_cnt == CW'(COLS - 1)) begin
                    col_cnt <= '0;
                    row_cnt <= (row_cnt == RW'(ROWS - 1)) ? '0 : row_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    // shift the column up one row and capture it for the output
    always_ff @(posedge clk) begin
        if (i_pix_valid) begin
            for (int k = 0; k < NBUF - 1; k++) begin
                rows_q[k][col_cnt] <= rows_q[k + 1][col_cnt];
            end
            rows_q[NBUF - 1][col_cnt] <= i_pix;

            for (int k = 0; k < NBUF; k++) begin
                pix_q[k] <= rows_q[k][col_cnt];
            end
            pix_q[WIN - 1] <= i_pix;
            first_q <= (col_cnt == '0);
        end
    end

    assign o_col = '{valid: valid_q, first: first_q, pix: pix_q};

endmodule

`default_nettype wire

//--- src/box_pkg.sv
`default_nettype none

package box_pkg;

    // pixel and window geometry
    localparam int PIX_W = 8;
    localparam int WIN = 5;

    // one column of five pixels needs 11 bits, 25 pixels need 13
    localparam int COLSUM_W = 11;
    localparam int SUM_W = 13;

    // vertical column from the line buffer
    // pix[0] is the oldest row, pix[WIN-1] the pixel just accepted
    typedef struct packed {
        logic                      valid;
        logic                      first;
        logic [WIN-1:0][PIX_W-1:0] pix;
    } col_t;

    // one complete 5x5 window
    typedef struct packed {
        logic             valid;
        logic [SUM_W-1:0] sum;
        logic [PIX_W-1:0] center;
    } win_t;

    // threshold configuration
    typedef struct packed {
        logic [SUM_W-1:0] offset;
        logic             invert;
    } cfg_t;

    typedef enum logic [0:0] {
        CFG_OFFSET = 1'b0,
        CFG_INVERT = 1'b1
    } cfg_addr_e;

endpackage

`default_nettype wire
